/* verilog/decodePkg.sv */
// Opcode encoding, micro-op word views, decoded bundle, Wishbone bus structs and shared constants

package decodePkg;

	// ======================================================================
	// Shared constants
	// ======================================================================

	// First fetch address after reset
	localparam logic [31:0] resetPc = 32'h0000_0000;
	// Every micro-op word is four bytes wide, so fetch steps by this much
	localparam logic [31:0] instrBytes = 32'd4;
	// Width of a register number in the micro-op word
	localparam int regBits = 6;

	// ======================================================================
	// Opcode encoding
	// ======================================================================

	// Groups sit in separate rows of sixteen so a dump is easy to read
	typedef enum logic [6:0]
	{
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h01,
		OP_ADDI  = 7'h02,
		OP_LDB   = 7'h10,
		OP_LDBZ  = 7'h11,
		OP_LDW   = 7'h12,
		OP_LDWZ  = 7'h13,
		OP_LDT   = 7'h14,
		OP_LDTZ  = 7'h15,
		OP_LOAD  = 7'h16,
		OP_LDV   = 7'h17,
		OP_LDVN  = 7'h18,
		OP_STB   = 7'h20,
		OP_STW   = 7'h21,
		OP_STT   = 7'h22,
		OP_STORE = 7'h23,
		OP_STV   = 7'h24,
		OP_BEQ   = 7'h30,
		OP_BNE   = 7'h31,
		OP_JMP   = 7'h32
	} opcode_t;

	// ======================================================================
	// Micro-op word, read either in register layout or immediate layout
	// ======================================================================

	typedef union packed
	{
		// Opcode only, used by the classifiers
		struct packed
		{
			opcode_t opcode;
			logic [24:0] rest;
		} any;
		// Three register operands and a function field
		struct packed
		{
			opcode_t opcode;
			logic [regBits-1:0] rd;
			logic [regBits-1:0] rs1;
			logic [regBits-1:0] rs2;
			logic [6:0] func;
		} regForm;
		// Two register operands and a 13-bit signed immediate
		struct packed
		{
			opcode_t opcode;
			logic [regBits-1:0] rd;
			logic [regBits-1:0] rs1;
			logic [12:0] imm;
		} immForm;
	} microOp_t;

	// Bundle handed to the consumer of the decode stage
	typedef struct packed
	{
		logic [31:0] pc;
		opcode_t opcode;
		logic [regBits-1:0] rd;
		logic [regBits-1:0] rs1;
		logic [regBits-1:0] rs2;
		logic [31:0] imm;
		logic hasImm;
		logic load;
		logic vload;
		logic vloadNdx;
		logic store;
		logic vstore;
		logic branch;
		logic jump;
		logic writesRd;
	} decodedOp_t;

	// Wishbone classic master request and slave response
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [3:0] sel;
	} wbReq_t;

	typedef struct packed
	{
		logic ack;
		logic [31:0] dat;
	} wbResp_t;

endpackage

/* verilog/decodeLoad.sv */
// Load classifier that flags scalar, vector and indexed vector load opcodes
`timescale 1ns/1ps

module decodeLoad
(
	input decodePkg::microOp_t instr,
	output logic load,
	output logic vload,
	output logic vloadNdx
);

	import decodePkg::*;

	// Only the opcode matters here, so the plain view is used
	always_comb
	begin
		load = 1'b0;
		vload = 1'b0;
		vloadNdx = 1'b0;
		case (instr.any.opcode)
			// Byte, wyde and tetra loads, signed and zero extended, plus the full load
			OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD:
				load = 1'b1;
			// Unit stride vector load
			OP_LDV:
				vload = 1'b1;
			// Indexed vector load, a gather
			OP_LDVN:
				vloadNdx = 1'b1;
			default:
				load = 1'b0;
		endcase
	end

endmodule

/* verilog/decodeStore.sv */
// Store classifier that flags scalar and vector store opcodes
`timescale 1ns/1ps

module decodeStore
(
	input decodePkg::microOp_t instr,
	output logic store,
	output logic vstore
);

	import decodePkg::*;

	always_comb
	begin
		store = 1'b0;
		vstore = 1'b0;
		case (instr.any.opcode)
			// Four scalar store widths
			OP_STB, OP_STW, OP_STT, OP_STORE:
				store = 1'b1;
			// Vector store
			OP_STV:
				vstore = 1'b1;
			default:
				store = 1'b0;
		endcase
	end

endmodule

/* verilog/decodeFlow.sv */
// Control flow classifier for branches and jumps, plus the destination write flag
`timescale 1ns/1ps

module decodeFlow
(
	input decodePkg::microOp_t instr,
	output logic branch,
	output logic jump,
	output logic writesRd
);

	import decodePkg::*;

	always_comb
	begin
		branch = 1'b0;
		jump = 1'b0;
		writesRd = 1'b0;
		case (instr.any.opcode)
			// Conditional branches compare two sources and write nothing
			OP_BEQ, OP_BNE:
				branch = 1'b1;
			// The jump leaves its return address in rd
			OP_JMP:
			begin
				jump = 1'b1;
				writesRd = 1'b1;
			end
			// ALU results go to rd
			OP_ADD, OP_ADDI:
				writesRd = 1'b1;
			// Every load, scalar or vector, fills its destination
			OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD,
			OP_LDV, OP_LDVN:
				writesRd = 1'b1;
			// Stores and OP_NOP fall through with all flags clear
			default:
				writesRd = 1'b0;
		endcase
	end

endmodule

/* verilog/decodeRegs.sv */
// Operand extractor that picks the word layout and produces register numbers and immediate
`timescale 1ns/1ps

module decodeRegs
(
	input decodePkg::microOp_t instr,
	output logic [decodePkg::regBits-1:0] rd,
	output logic [decodePkg::regBits-1:0] rs1,
	output logic [decodePkg::regBits-1:0] rs2,
	output logic [31:0] imm,
	output logic hasImm
);

	import decodePkg::*;

	// Immediate layout is used by everything that carries an offset or constant
	always_comb
	begin
		case (instr.any.opcode)
			OP_ADDI:
				hasImm = 1'b1;
			OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD,
			OP_LDV, OP_LDVN:
				hasImm = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STORE, OP_STV:
				hasImm = 1'b1;
			OP_BEQ, OP_BNE, OP_JMP:
				hasImm = 1'b1;
			// OP_ADD, OP_NOP and anything unknown read as register layout
			default:
				hasImm = 1'b0;
		endcase
	end

	// Field extraction from whichever view applies
	always_comb
	begin
		if (hasImm)
		begin
			rd = instr.immForm.rd;
			rs1 = instr.immForm.rs1;
			// No second source register exists in this layout
			rs2 = '0;
			// Replicate bit 12 to widen the offset to a full word
			imm = {{19{instr.immForm.imm[12]}}, instr.immForm.imm};
		end
		else
		begin
			rd = instr.regForm.rd;
			rs1 = instr.regForm.rs1;
			rs2 = instr.regForm.rs2;
			imm = '0;
		end
	end

endmodule

/* verilog/fetchWb.sv */
// Wishbone classic instruction fetch master with a single-word holding buffer
`timescale 1ns/1ps

module fetchWb
(
	input logic clk,
	input logic rst,
	output decodePkg::wbReq_t wbReq,
	input decodePkg::wbResp_t wbResp,
	output decodePkg::microOp_t fetchWord,
	output logic [31:0] fetchPc,
	output logic fetchValid,
	input logic fetchReady
);

	import decodePkg::*;

	// Address of the word the next bus cycle reads
	logic [31:0] pc;
	// High for the whole of a bus cycle, stb follows it
	logic cyc;
	// Last cycle of the bus access
	logic ackTaken;
	// The buffer is free now or is handed over at this edge
	logic bufFree;

	assign ackTaken = cyc & wbResp.ack;
	assign bufFree = ~fetchValid | fetchReady;

	// Read-only access over all four byte lanes
	always_comb
	begin
		wbReq.cyc = cyc;
		wbReq.stb = cyc;
		wbReq.we = 1'b0;
		wbReq.adr = pc;
		wbReq.sel = 4'hF;
	end

	// ======================================================================
	// Bus cycle control
	// ======================================================================

	// Cycle ends at the ack edge, so cyc is low for at least one cycle before
	// the next start. A start waits until the buffer will have room, which
	// means the buffer is always empty when the following ack arrives
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cyc <= 1'b0;
			pc <= resetPc;
		end
		else if (ackTaken)
		begin
			cyc <= 1'b0;
			pc <= pc + instrBytes;
		end
		else if (!cyc && bufFree)
			cyc <= 1'b1;
	end

	// ======================================================================
	// Holding buffer
	// ======================================================================

	// Valid flag rises the cycle after ack and drops once decode takes the word
	always_ff @(posedge clk)
	begin
		if (rst)
			fetchValid <= 1'b0;
		else if (ackTaken)
			fetchValid <= 1'b1;
		else if (fetchReady)
			fetchValid <= 1'b0;
	end

	// Word and its address are captured together
	always_ff @(posedge clk)
	begin
		if (ackTaken)
		begin
			fetchWord <= wbResp.dat;
			fetchPc <= pc;
		end
	end

endmodule

/* verilog/decodeStage.sv */
// One-entry decode pipeline stage that merges the classifier outputs into a decoded bundle
`timescale 1ns/1ps

module decodeStage
(
	input logic clk,
	input logic rst,
	input decodePkg::microOp_t fetchWord,
	input logic [31:0] fetchPc,
	input logic fetchValid,
	output logic fetchReady,
	output decodePkg::decodedOp_t dec,
	output logic decValid,
	input logic decReady
);

	import decodePkg::*;

	// Bundle built from the incoming word, registered on a transfer
	decodedOp_t nextDec;

	// ======================================================================
	// Classifiers, all working on the word in parallel
	// ======================================================================

	decodeLoad loadInst
	(
		.instr(fetchWord),
		.load(nextDec.load),
		.vload(nextDec.vload),
		.vloadNdx(nextDec.vloadNdx)
	);

	decodeStore storeInst
	(
		.instr(fetchWord),
		.store(nextDec.store),
		.vstore(nextDec.vstore)
	);

	decodeFlow flowInst
	(
		.instr(fetchWord),
		.branch(nextDec.branch),
		.jump(nextDec.jump),
		.writesRd(nextDec.writesRd)
	);

	decodeRegs regsInst
	(
		.instr(fetchWord),
		.rd(nextDec.rd),
		.rs1(nextDec.rs1),
		.rs2(nextDec.rs2),
		.imm(nextDec.imm),
		.hasImm(nextDec.hasImm)
	);

	// Address and opcode pass straight into the bundle
	assign nextDec.pc = fetchPc;
	assign nextDec.opcode = fetchWord.any.opcode;

	// ======================================================================
	// Flow control
	// ======================================================================

	// Room exists when the stage is empty or its bundle leaves this cycle
	assign fetchReady = ~decValid | decReady;

	always_ff @(posedge clk)
	begin
		if (rst)
			decValid <= 1'b0;
		else if (fetchReady)
			decValid <= fetchValid;
	end

	// Bundle only changes on an accepted word, so it holds during a stall
	always_ff @(posedge clk)
	begin
		if (fetchValid && fetchReady)
			dec <= nextDec;
	end

endmodule

/* verilog/decodeTop.sv */
// Decode front end top level joining the fetch master to the decode stage
`timescale 1ns/1ps

module decodeTop
(
	input logic clk,
	input logic rst,
	output decodePkg::wbReq_t wbReq,
	input decodePkg::wbResp_t wbResp,
	output decodePkg::decodedOp_t dec,
	output logic decValid,
	input logic decReady
);

	import decodePkg::*;

	// Handoff between the fetch buffer and the decode register
	microOp_t fetchWord;
	logic [31:0] fetchPc;
	logic fetchValid;
	logic fetchReady;

	fetchWb fetchInst
	(
		.clk(clk),
		.rst(rst),
		.wbReq(wbReq),
		.wbResp(wbResp),
		.fetchWord(fetchWord),
		.fetchPc(fetchPc),
		.fetchValid(fetchValid),
		.fetchReady(fetchReady)
	);

	decodeStage stageInst
	(
		.clk(clk),
		.rst(rst),
		.fetchWord(fetchWord),
		.fetchPc(fetchPc),
		.fetchValid(fetchValid),
		.fetchReady(fetchReady),
		.dec(dec),
		.decValid(decValid),
		.decReady(decReady)
	);

endmodule

/* dv/decodeTop_asserts.sv */
// Concurrent assertions on the Wishbone fetch bus and the decoded output handshake
`timescale 1ns/1ps

module decodeTop_asserts
(
	input logic clk,
	input logic rst,
	input decodePkg::wbReq_t wbReq,
	input decodePkg::wbResp_t wbResp,
	input decodePkg::decodedOp_t dec,
	input logic decValid,
	input logic decReady
);

	import decodePkg::*;

	// Number of assertion failures, read by the testbench for its final verdict
	int failCount = 0;

	// Strobe and cycle rise and fall together on this single-access master
	stbFollowsCyc: assert property (@(posedge clk) disable iff (rst) wbReq.stb == wbReq.cyc)
	else
	begin
		$error("stb differs from cyc");
		failCount++;
	end

	// An open access keeps its address and control lines until the slave acks
	reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
		(wbReq.cyc && !wbResp.ack) |=> (wbReq.cyc && $stable(wbReq)))
	else
	begin
		$error("bus request changed before ack");
		failCount++;
	end

	// A stalled bundle must not move
	decHeldWhileStalled: assert property (@(posedge clk) disable iff (rst)
		(decValid && !decReady) |=> (decValid && $stable(dec)))
	else
	begin
		$error("decoded bundle changed while stalled");
		failCount++;
	end

	// dec has no reset, so it only counts while decValid is high
	noUnknownOutputs: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(wbReq) && !$isunknown(decValid) && (!decValid || !$isunknown(dec)))
	else
	begin
		$error("unknown value on a DUT output");
		failCount++;
	end

endmodule

/* dv/decodeChecker.sv */
// Checker with the reference decode function, bus address tracking and in-order bundle compare
`timescale 1ns/1ps

module decodeChecker
(
	input logic clk,
	input logic rst,
	input decodePkg::wbReq_t wbReq,
	input decodePkg::wbResp_t wbResp,
	input decodePkg::decodedOp_t dec,
	input logic decValid,
	input logic decReady,
	output int checked,
	output int mismatches,
	output int otherErrors
);

	import decodePkg::*;

	// Fetched words still waiting for their bundle with the address in the upper half
	logic [63:0] pending [$];
	// Address the next ack should carry
	logic [31:0] expAdr;
	// High until the first cycle out of reset has been looked at
	logic firstCycle;
	logic [63:0] entry;
	decodedOp_t expDec;

	initial
	begin
		checked = 0;
		mismatches = 0;
		otherErrors = 0;
	end

	// ======================================================================
	// Reference decode built from the opcode rules
	// ======================================================================

	function automatic decodedOp_t refDecode(input logic [31:0] pc, input logic [31:0] word);
		decodedOp_t r;
		opcode_t op;
		logic isLoad;
		op = opcode_t'(word[31:25]);
		isLoad = op inside {OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD};
		r = '0;
		r.pc = pc;
		r.opcode = op;
		r.load = isLoad;
		r.vload = (op == OP_LDV);
		r.vloadNdx = (op == OP_LDVN);
		r.store = op inside {OP_STB, OP_STW, OP_STT, OP_STORE};
		r.vstore = (op == OP_STV);
		r.branch = op inside {OP_BEQ, OP_BNE};
		r.jump = (op == OP_JMP);
		// The jump writes its link register
		r.writesRd = isLoad | r.vload | r.vloadNdx | (op inside {OP_ADD, OP_ADDI, OP_JMP});
		r.hasImm = (op == OP_ADDI) | isLoad | r.vload | r.vloadNdx | r.store | r.vstore
			| r.branch | r.jump;
		// rd and rs1 sit in the same bits in both layouts
		r.rd = word[24:19];
		r.rs1 = word[18:13];
		// The offset is a signed 13-bit value widened to a full word
		if (r.hasImm)
			r.imm = $signed(word[12:0]);
		else
			r.rs2 = word[12:7];
		return r;
	endfunction

	task automatic compareField(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			$display("Mismatch at %0t ns: dec.%s expected %h actual %h", $time, name,
				expVal, actVal);
			mismatches++;
		end
	endtask

	// ======================================================================
	// Compare process
	// ======================================================================

	always @(posedge clk)
	begin
		if (rst)
		begin
			pending.delete();
			expAdr = resetPc;
			firstCycle = 1'b1;
		end
		else
		begin
			if (firstCycle && (wbReq.cyc || wbReq.stb || decValid))
			begin
				$display("cyc, stb or decValid was high in the first cycle after reset");
				otherErrors++;
			end
			firstCycle = 1'b0;
			// A bundle never comes from the ack of the same cycle, so the pop goes first
			if (decValid && decReady)
			begin
				if (pending.size() == 0)
				begin
					$display("At %0t ns a bundle was taken with no fetched word outstanding",
						$time);
					otherErrors++;
				end
				else
				begin
					entry = pending.pop_front();
					expDec = refDecode(entry[63:32], entry[31:0]);
					compareField("pc", expDec.pc, dec.pc);
					compareField("opcode", expDec.opcode, dec.opcode);
					compareField("rd", expDec.rd, dec.rd);
					compareField("rs1", expDec.rs1, dec.rs1);
					compareField("rs2", expDec.rs2, dec.rs2);
					compareField("imm", expDec.imm, dec.imm);
					compareField("hasImm", expDec.hasImm, dec.hasImm);
					compareField("load", expDec.load, dec.load);
					compareField("vload", expDec.vload, dec.vload);
					compareField("vloadNdx", expDec.vloadNdx, dec.vloadNdx);
					compareField("store", expDec.store, dec.store);
					compareField("vstore", expDec.vstore, dec.vstore);
					compareField("branch", expDec.branch, dec.branch);
					compareField("jump", expDec.jump, dec.jump);
					compareField("writesRd", expDec.writesRd, dec.writesRd);
				end
				checked++;
			end
			// Every access is a read over all four byte lanes
			if (wbReq.cyc)
			begin
				if (wbReq.we !== 1'b0)
				begin
					$display("Mismatch at %0t ns: wbReq.we expected 0 actual %b", $time,
						wbReq.we);
					mismatches++;
				end
				if (wbReq.sel !== 4'hF)
				begin
					$display("Mismatch at %0t ns: wbReq.sel expected f actual %h", $time,
						wbReq.sel);
					mismatches++;
				end
			end
			// Each bus read must follow the previous one by one word
			if (wbReq.cyc && wbReq.stb && wbResp.ack)
			begin
				if (wbReq.adr !== expAdr)
				begin
					$display("Mismatch at %0t ns: wbReq.adr expected %h actual %h", $time,
						expAdr, wbReq.adr);
					mismatches++;
				end
				pending.push_back({wbReq.adr, wbResp.dat});
				expAdr = expAdr + instrBytes;
			end
		end
	end

endmodule

/* dv/decodeTb.sv */
// Testbench top with clock, reset, LFSR, Wishbone memory model, ready stimulus and watchdog
`timescale 1ns/1ps

module decodeTb;

	import decodePkg::*;

	localparam int clkPeriodNs = 8;
	localparam int resetCycles = 5;
	localparam int numWords = 200;
	localparam int cyclesPerWord = 20;
	localparam int timeoutNs = numWords * cyclesPerWord * clkPeriodNs;

	// Opcodes the memory model picks from
	localparam opcode_t opList [20] = '{OP_ADD, OP_ADDI, OP_NOP, OP_LDB, OP_LDBZ, OP_LDW,
		OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD, OP_LDV, OP_LDVN, OP_STB, OP_STW, OP_STT, OP_STORE,
		OP_STV, OP_BEQ, OP_BNE, OP_JMP};

	logic clk;
	logic rst;
	wbReq_t wbReq;
	wbResp_t wbResp;
	decodedOp_t dec;
	logic decValid;
	logic decReady;
	int checked;
	int mismatches;
	int otherErrors;
	int totalErrors;

	logic [15:0] lfsrState;
	logic [31:0] mem [256];
	int ackDelay;
	logic accessOpen;

	decodeTop dut_i (.*);

	decodeChecker checkerInst (.*);

	bind decodeTop decodeTop_asserts assertsInst (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriodNs / 2) clk = ~clk;
	end

	// Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit handed out
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		logic fb;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// ======================================================================
	// Wishbone slave model that acks after 0 to 3 wait cycles
	// ======================================================================

	task automatic serveBus();
		if (wbResp.ack)
		begin
			wbResp = '0;
			accessOpen = 1'b0;
		end
		else if (wbReq.cyc && wbReq.stb)
		begin
			if (!accessOpen)
			begin
				ackDelay = takeBits(2);
				accessOpen = 1'b1;
			end
			if (ackDelay == 0)
			begin
				wbResp.ack = 1'b1;
				wbResp.dat = mem[wbReq.adr[9:2]];
			end
			else
				ackDelay--;
		end
	endtask

	// Stimulus runs on the falling edge only
	initial
	begin
		logic [31:0] opSel;
		logic [31:0] restBits;
		int i;
		rst = 1'b1;
		decReady = 1'b0;
		wbResp = '0;
		ackDelay = 0;
		accessOpen = 1'b0;
		lfsrState = 16'd52;
		for (i = 0; i < 256; i++)
		begin
			opSel = takeBits(5);
			restBits = takeBits(25);
			mem[i] = {opList[opSel % 20], restBits[24:0]};
		end
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;
		forever
		begin
			@(negedge clk);
			serveBus();
			decReady = (takeBits(1) != 0);
		end
	end

	// Run ends once the checker has seen every word
	initial
	begin
		wait (checked >= numWords);
		@(negedge clk);
		totalErrors = mismatches + otherErrors + dut_i.assertsInst.failCount;
		$display("Checked %0d bundles with %0d mismatches, %0d other errors, %0d assertion errors",
			checked, mismatches, otherErrors, dut_i.assertsInst.failCount);
		if (totalErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		#(timeoutNs);
		$display("Watchdog expired after %0d ns with only %0d bundles checked", timeoutNs,
			checked);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* project.f */
verilog/decodePkg.sv
verilog/decodeLoad.sv
verilog/decodeStore.sv
verilog/decodeFlow.sv
verilog/decodeRegs.sv
verilog/fetchWb.sv
verilog/decodeStage.sv
verilog/decodeTop.sv
dv/decodeTop_asserts.sv
dv/decodeChecker.sv
dv/decodeTb.sv
